/* rtl/mul16_pkg.sv */
/*
  Shared definitions for the 16x16 multiplier
  Operand and product widths, lane count, CLA group size,
  Wishbone register map and the sequencer state encoding
*/
package mul16_pkg;

  // Operand halves and full widths
  localparam int HALF_W = 8;
  localparam int OP_W   = 16;

  // Product width, also the Wishbone data width
  localparam int PROD_W = 32;

  // Partial-product lanes
  // 0 = lo*lo, 1 = hi a * lo b, 2 = lo a * hi b, 3 = hi*hi
  localparam int LANES = 4;

  // Bits per carry-lookahead group
  localparam int CLA_GRP = 4;

  // Wishbone word address width
  localparam int ADR_W = 2;

  // Register map
  typedef enum logic [ADR_W-1:0] {
    REG_OPERANDS = 2'd0,  // a in 15:0, b in 31:16
    REG_PRODUCT  = 2'd1,
    REG_STATUS   = 2'd2   // state in 1:0
  } wb_reg_e;

  // Multiply sequencer
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2
  } mul_state_e;

endpackage

/* rtl/cla_adder32.sv */
/*
  32-bit carry-lookahead adder
  Bit propagate and generate, group P and G per 4-bit group,
  second-level lookahead for group carries, then in-group
  lookahead for the sum bits
*/
`timescale 1ns/1ps

module cla_adder32 import mul16_pkg::*; (
  input  logic [PROD_W-1:0] a,
  input  logic [PROD_W-1:0] b,
  output logic [PROD_W-1:0] sum
);

  logic [PROD_W-1:0]           p;
  logic [PROD_W-1:0]           g;
  logic [PROD_W/CLA_GRP-1:0]   grp_p;
  logic [PROD_W/CLA_GRP-1:0]   grp_g;
  logic [PROD_W/CLA_GRP-1:0]   grp_c;

  // Group generate as a flat sum of products
  function automatic logic grp_gen(input logic [CLA_GRP-1:0] pv,
                                   input logic [CLA_GRP-1:0] gv);
    logic gen;
    logic term;
    gen = 1'b0;
    for (int m = 0; m < CLA_GRP; m++) begin
      term = gv[m];
      for (int n = m + 1; n < CLA_GRP; n++) begin
        term = term & pv[n];
      end
      gen = gen | term;
    end
    return gen;
  endfunction

  // Carry into each bit of a group
  function automatic logic [CLA_GRP-1:0] bit_carries(input logic [CLA_GRP-1:0] pv,
                                                     input logic [CLA_GRP-1:0] gv,
                                                     input logic cin);
    logic [CLA_GRP-1:0] cy;
    logic term;
    for (int i = 0; i < CLA_GRP; i++) begin
      cy[i] = cin;
      for (int m = 0; m < i; m++) begin
        cy[i] = cy[i] & pv[m];
      end
      for (int m = 0; m < i; m++) begin
        term = gv[m];
        for (int n = m + 1; n < i; n++) begin
          term = term & pv[n];
        end
        cy[i] = cy[i] | term;
      end
    end
    return cy;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  // Second level, no carry in
  always_comb begin : p_grp_carry
    logic term;
    grp_c = '0;
    for (int k = 1; k < PROD_W / CLA_GRP; k++) begin
      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & grp_p[n];
        end
        grp_c[k] = grp_c[k] | term;
      end
    end
  end

  for (genvar k = 0; k < PROD_W / CLA_GRP; k++) begin : g_grp
    logic [CLA_GRP-1:0] gp;
    logic [CLA_GRP-1:0] gg;
    logic [CLA_GRP-1:0] cy;
    assign gp       = p[k*CLA_GRP +: CLA_GRP];
    assign gg       = g[k*CLA_GRP +: CLA_GRP];
    assign grp_p[k] = &gp;
    assign grp_g[k] = grp_gen(gp, gg);
    assign cy       = bit_carries(gp, gg, grp_c[k]);
    assign sum[k*CLA_GRP +: CLA_GRP] = gp ^ cy;
  end

endmodule

/* rtl/mul8_array.sv */
/*
  Exact 8x8 unsigned carry-save array multiplier
  AND plane, rows of full adders passing sum and carry down,
  a ripple row for the upper half, registered output
*/
`timescale 1ns/1ps

module mul8_array import mul16_pkg::*; (
  input  logic                  clk,
  input  logic [HALF_W-1:0]     a,
  input  logic [HALF_W-1:0]     b,
  output logic [2*HALF_W-1:0]   prod
);

  logic [HALF_W-1:0] pp [HALF_W];
  logic [HALF_W-1:0] s  [HALF_W];
  logic [HALF_W-1:0] c  [HALF_W];
  logic [HALF_W-1:0] lo;
  logic [HALF_W-1:0] hi;
  logic [HALF_W-1:0] r;

  // One AND row per multiplier bit
  for (genvar j = 0; j < HALF_W; j++) begin : g_and
    assign pp[j] = a & {HALF_W{b[j]}};
  end

  assign s[0] = pp[0];
  assign c[0] = '0;

  // Row j, cell i sits at weight i+j
  for (genvar j = 1; j < HALF_W; j++) begin : g_row
    for (genvar i = 0; i < HALF_W; i++) begin : g_cell
      logic s_in;
      if (i == HALF_W - 1) begin : g_edge
        assign s_in = 1'b0;
      end else begin : g_inner
        assign s_in = s[j-1][i+1];
      end
      assign s[j][i] = pp[j][i] ^ s_in ^ c[j-1][i];
      assign c[j][i] = (pp[j][i] & s_in) | (c[j-1][i] & (pp[j][i] ^ s_in));
    end
  end

  // Lower half drops out of the array one bit per row
  for (genvar j = 0; j < HALF_W; j++) begin : g_lo
    assign lo[j] = s[j][0];
  end

  // Final ripple row resolves the remaining sums and carries
  assign r[0] = 1'b0;
  for (genvar k = 0; k < HALF_W - 1; k++) begin : g_ripple
    logic x;
    logic y;
    assign x        = s[HALF_W-1][k+1];
    assign y        = c[HALF_W-1][k];
    assign hi[k]    = x ^ y ^ r[k];
    assign r[k+1]   = (x & y) | (r[k] & (x ^ y));
  end
  // Product fits in 16 bits so the top column cannot carry
  assign hi[HALF_W-1] = c[HALF_W-1][HALF_W-1] ^ r[HALF_W-1];

  always_ff @(posedge clk) begin
    prod <= {hi, lo};
  end

endmodule

/* rtl/mul16_operand_split.sv */
/*
  Operand splitter
  Cuts both 16-bit operands into halves and registers the
  pairs for the four partial-product lanes on start
*/
`timescale 1ns/1ps

module mul16_operand_split import mul16_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic [OP_W-1:0]              op_a,
  input  logic [OP_W-1:0]              op_b,
  output logic [LANES-1:0][HALF_W-1:0] lane_a,
  output logic [LANES-1:0][HALF_W-1:0] lane_b,
  output logic                         lane_valid
);

  // Lane index bit 0 picks the half of a, bit 1 the half of b
  always_ff @(posedge clk) begin
    if (start) begin
      for (int i = 0; i < LANES; i++) begin
        lane_a[i] <= op_a[(i % 2) * HALF_W +: HALF_W];
        lane_b[i] <= op_b[(i / 2) * HALF_W +: HALF_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= start;
    end
  end

endmodule

/* rtl/mul16_product_combine.sv */
/*
  Partial product combiner
  Places hi*hi over lo*lo, adds both cross products shifted
  by one half through two CLAs and registers the result
*/
`timescale 1ns/1ps

module mul16_product_combine import mul16_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           lane_valid,
  input  logic [LANES-1:0][2*HALF_W-1:0] lane_prod,
  output logic [PROD_W-1:0]              product,
  output logic                           product_valid
);

  logic [PROD_W-1:0] outer_pair;
  logic [PROD_W-1:0] cross_hl;
  logic [PROD_W-1:0] cross_lh;
  logic [PROD_W-1:0] partial_sum;
  logic [PROD_W-1:0] full_sum;
  logic              prod_stage;

  // Outer lanes do not overlap
  assign outer_pair = {lane_prod[LANES-1], lane_prod[0]};
  assign cross_hl   = {{HALF_W{1'b0}}, lane_prod[1], {HALF_W{1'b0}}};
  assign cross_lh   = {{HALF_W{1'b0}}, lane_prod[2], {HALF_W{1'b0}}};

  cla_adder32 u_add_hl (
    .a   (outer_pair),
    .b   (cross_hl),
    .sum (partial_sum)
  );

  cla_adder32 u_add_lh (
    .a   (partial_sum),
    .b   (cross_lh),
    .sum (full_sum)
  );

  // Lane products lag lane_valid by one register
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_stage    <= 1'b0;
      product_valid <= 1'b0;
    end else begin
      prod_stage    <= lane_valid;
      product_valid <= prod_stage;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_stage) begin
      product <= full_sum;
    end
  end

endmodule

/* rtl/mul16_wb_regs.sv */
/*
  Wishbone classic slave for the multiplier
  Holds operand, product and status registers, returns a
  registered one-cycle ack and sequences a single multiply
  at a time through the lane pipeline
*/
`timescale 1ns/1ps

module mul16_wb_regs import mul16_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADR_W-1:0]  wb_adr,
  input  logic [PROD_W-1:0] wb_dat_w,
  output logic [PROD_W-1:0] wb_dat_r,
  output logic              wb_ack,
  output logic              start,
  output logic [OP_W-1:0]   op_a,
  output logic [OP_W-1:0]   op_b,
  input  logic [PROD_W-1:0] product,
  input  logic              product_valid
);

  mul_state_e        state;
  wb_reg_e           reg_sel;
  logic              req;
  logic              accept;
  logic [PROD_W-1:0] product_q;
  logic [PROD_W-1:0] rd_data;

  // New cycle seen, not yet acknowledged
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  assign reg_sel = wb_reg_e'(wb_adr);

  // Operand write starts a multiply only when the pipeline is free
  assign accept = req & wb_we & (reg_sel == REG_OPERANDS) & (state != ST_BUSY);

  always_comb begin
    case (reg_sel)
      REG_OPERANDS: rd_data = {op_b, op_a};
      REG_PRODUCT:  rd_data = product_q;
      REG_STATUS:   rd_data = {{(PROD_W - 2){1'b0}}, state};
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
    end else begin
      wb_ack <= req;
      start  <= accept;
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_a <= wb_dat_w[OP_W-1:0];
      op_b <= wb_dat_w[PROD_W-1:OP_W];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      product_q <= '0;
    end else begin
      if (product_valid) begin
        product_q <= product;
      end
      case (state)
        ST_IDLE, ST_DONE: begin
          if (accept) begin
            state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (product_valid) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* rtl/mul16_top.sv */
/*
  16x16 unsigned multiplier with Wishbone classic access
  Register slave, operand splitter, four exact 8x8 lanes
  and the CLA-based product combiner
*/
`timescale 1ns/1ps

module mul16_top import mul16_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADR_W-1:0]  wb_adr,
  input  logic [PROD_W-1:0] wb_dat_w,
  output logic [PROD_W-1:0] wb_dat_r,
  output logic              wb_ack
);

  logic                           start;
  logic [OP_W-1:0]                op_a;
  logic [OP_W-1:0]                op_b;
  logic [LANES-1:0][HALF_W-1:0]   lane_a;
  logic [LANES-1:0][HALF_W-1:0]   lane_b;
  logic                           lane_valid;
  logic [LANES-1:0][2*HALF_W-1:0] lane_prod;
  logic [PROD_W-1:0]              product;
  logic                           product_valid;

  mul16_wb_regs u_regs (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .start         (start),
    .op_a          (op_a),
    .op_b          (op_b),
    .product       (product),
    .product_valid (product_valid)
  );

  mul16_operand_split u_split (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .op_a       (op_a),
    .op_b       (op_b),
    .lane_a     (lane_a),
    .lane_b     (lane_b),
    .lane_valid (lane_valid)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    mul8_array u_mul (
      .clk  (clk),
      .a    (lane_a[i]),
      .b    (lane_b[i]),
      .prod (lane_prod[i])
    );
  end

  mul16_product_combine u_combine (
    .clk           (clk),
    .rst           (rst),
    .lane_valid    (lane_valid),
    .lane_prod     (lane_prod),
    .product       (product),
    .product_valid (product_valid)
  );

endmodule

/* dv/mul16_checker.sv */
/*
  Wishbone and sequencer assertions for the register slave
  Bound into mul16_wb_regs
*/
`timescale 1ns/1ps

module mul16_checker import mul16_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_ack,
  input logic       product_valid,
  input mul_state_e state
);

  int fail_count = 0;

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      $error("ack raised outside an active bus cycle");
      fail_count++;
    end

  a_ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else begin
      $error("ack held high for two cycles");
      fail_count++;
    end

  a_done_after_valid: assert property (@(posedge clk) disable iff (rst)
    product_valid |=> (state == ST_DONE))
    else begin
      $error("state not done after product_valid");
      fail_count++;
    end

endmodule

bind mul16_wb_regs mul16_checker u_chk (
  .clk           (clk),
  .rst           (rst),
  .wb_cyc        (wb_cyc),
  .wb_stb        (wb_stb),
  .wb_ack        (wb_ack),
  .product_valid (product_valid),
  .state         (state)
);

/* dv/mul16_tb.sv */
/*
  Testbench for the Wishbone 16x16 multiplier
  Runs operand pairs from a data file and from an xorshift
  generator through the register interface and checks a*b
*/
`timescale 1ns/1ps

module mul16_tb import mul16_pkg::*; ();

  localparam int          ACK_TIMEOUT  = 20;
  localparam int          POLL_TIMEOUT = 40;
  localparam int          N_FILE       = 16;
  localparam int          N_RAND       = 200;
  localparam logic [31:0] SEED         = 32'd54;

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADR_W-1:0]  wb_adr;
  logic [PROD_W-1:0] wb_dat_w;
  logic [PROD_W-1:0] wb_dat_r;
  logic              wb_ack;

  logic [OP_W-1:0]   file_ops [2*N_FILE];
  logic [31:0]       rng;
  logic [OP_W-1:0]   last_a;
  logic [OP_W-1:0]   last_b;
  logic [PROD_W-1:0] rd;
  int                value_errors;
  int                proto_errors;
  int                assert_errors;

  mul16_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input string name, input logic [PROD_W-1:0] got,
                         input logic [PROD_W-1:0] expected);
    assert (got === expected) else begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected);
      value_errors++;
    end
  endtask

  // Request held until ack, bus released on the following edge
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [PROD_W-1:0] wdata,
                           output logic [PROD_W-1:0] rdata);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < ACK_TIMEOUT);
    rdata = wb_dat_r;
    assert (wb_ack) else begin
      $display("No ack within %0d cycles for access to address %0d", ACK_TIMEOUT, adr);
      proto_errors++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [PROD_W-1:0] data);
    logic [PROD_W-1:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input logic [ADR_W-1:0] adr, output logic [PROD_W-1:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic wait_done();
    logic [PROD_W-1:0] st;
    int polls;
    polls = 0;
    do begin
      read_reg(REG_STATUS, st);
      polls++;
    end while (st[1:0] != ST_DONE && polls < POLL_TIMEOUT);
    assert (st[1:0] == ST_DONE) else begin
      $display("Multiply not done after %0d status reads", POLL_TIMEOUT);
      proto_errors++;
    end
  endtask

  task automatic multiply_check(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b);
    logic [PROD_W-1:0] got;
    logic [PROD_W-1:0] expected;
    expected = PROD_W'(a) * PROD_W'(b);
    write_reg(REG_OPERANDS, {b, a});
    last_a = a;
    last_b = b;
    wait_done();
    read_reg(REG_PRODUCT, got);
    compare("product", got, expected);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    value_errors = 0;
    proto_errors = 0;
    rng          = SEED;
    $readmemh("dv/mul16_testdata.txt", file_ops);
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    read_reg(REG_STATUS, rd);
    compare("status", rd, PROD_W'(ST_IDLE));
    read_reg(REG_PRODUCT, rd);
    compare("product", rd, '0);

    for (int i = 0; i < N_FILE; i++) begin
      multiply_check(file_ops[2*i], file_ops[2*i+1]);
    end
    read_reg(REG_OPERANDS, rd);
    compare("operands", rd, {last_b, last_a});

    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      multiply_check(rng[15:0], rng[31:16]);
    end

    // Back-to-back write falls inside the busy window and is dropped
    write_reg(REG_OPERANDS, {16'h1357, 16'hbeef});
    write_reg(REG_OPERANDS, {16'h0002, 16'h0003});
    wait_done();
    read_reg(REG_PRODUCT, rd);
    compare("product", rd, 32'hbeef * 32'h1357);
    read_reg(REG_OPERANDS, rd);
    compare("operands", rd, {16'h1357, 16'hbeef});

    // Read-only and unmapped registers
    write_reg(REG_PRODUCT, 32'hdead_beef);
    write_reg(REG_STATUS, 32'h0000_0003);
    read_reg(REG_STATUS, rd);
    compare("status", rd, PROD_W'(ST_DONE));
    read_reg(REG_PRODUCT, rd);
    compare("product", rd, 32'hbeef * 32'h1357);
    read_reg(2'd3, rd);
    compare("unmapped", rd, '0);

    repeat (2) @(negedge clk);
    assert_errors = dut0.u_regs.u_chk.fail_count;
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errors, proto_errors, assert_errors);
    if (value_errors == 0 && proto_errors == 0 && assert_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* dv/mul16_testdata.txt */
// Operand pairs for the multiplier, one pair per line
// Columns: operand a, operand b (16-bit hex)
0000 0000
ffff ffff
0000 ffff
ffff 0000
0001 ffff
ffff 0001
00ff 00ff
ff00 ff00
00ff ff00
ff00 00ff
8000 8000
1234 5678
abcd ef01
7fff 8001
0100 0100
fffe 0002

/* mul16_top.f */
rtl/mul16_pkg.sv
rtl/cla_adder32.sv
rtl/mul8_array.sv
rtl/mul16_operand_split.sv
rtl/mul16_product_combine.sv
rtl/mul16_wb_regs.sv
rtl/mul16_top.sv
dv/mul16_checker.sv
dv/mul16_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mul16_tb -Mdir obj_dir -f mul16_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmul16_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
echo "Pass message not found"
exit 1
